//--- attitude_controller.sv
module attitude_controller #(
	parameter int KP_ANGLE_SHIFT = 2,
	parameter int KP_RATE_SHIFT = 1
) (
	input logic sys_clk,
	input logic resetn,
	input logic imu_valid,
	input flight_pkg::stick_t throttle_val,
	input flight_pkg::stick_t yaw_val,
	input flight_pkg::stick_t roll_val,
	input flight_pkg::stick_t pitch_val,
	input flight_pkg::imu_val_t euler_x,
	input flight_pkg::imu_val_t euler_y,
	input flight_pkg::imu_val_t gyro_x,
	input flight_pkg::imu_val_t gyro_y,
	input flight_pkg::imu_val_t gyro_z,
	rate_cmd_if.controller cmd
);

	flight_pkg::ctrl_state_t state;

	// Sample latched on imu_valid
	flight_pkg::stick_t thr_s, yaw_s, roll_s, pitch_s;
	flight_pkg::imu_val_t ex_s, ey_s, gx_s, gy_s, gz_s;

	logic signed [17:0] pitch_err, roll_err;           // Angle stage
	logic signed [17:0] pitch_tgt, roll_tgt, yaw_tgt;  // Rate targets
	logic signed [18:0] pitch_diff, roll_diff, yaw_diff;
	flight_pkg::rate_t thr_cmd, yaw_cmd, roll_cmd, pitch_cmd;

	// (stick - center) * 4
	function automatic logic signed [17:0] stick_offset(input flight_pkg::stick_t s);
		logic signed [17:0] v;
		v = $signed({10'b0, s}) - $signed(18'(flight_pkg::STICK_CENTER));
		return v <<< 2;
	endfunction

	function automatic flight_pkg::rate_t sat_rate(input logic signed [18:0] v);
		if (v > 19'sd32767)
			return 16'sh7FFF;
		else if (v < -19'sd32768)
			return 16'sh8000;
		else
			return v[15:0];
	endfunction

	always_comb begin
		pitch_err = stick_offset(pitch_s) - ex_s;  // Pitch about x
		roll_err = stick_offset(roll_s) - ey_s;    // Roll about y
		pitch_diff = pitch_tgt - gx_s;
		roll_diff = roll_tgt - gy_s;
		yaw_diff = yaw_tgt - gz_s;
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			state <= flight_pkg::IDLE;
			thr_cmd <= '0;
			yaw_cmd <= '0;
			roll_cmd <= '0;
			pitch_cmd <= '0;
		end else begin
			case (state)
				flight_pkg::IDLE: if (imu_valid) state <= flight_pkg::ANGLE;
				flight_pkg::ANGLE: state <= flight_pkg::RATE;
				flight_pkg::RATE: begin
					state <= flight_pkg::DONE;
					thr_cmd <= flight_pkg::rate_t'({6'b0, thr_s, 2'b00});
					yaw_cmd <= sat_rate(yaw_diff >>> KP_RATE_SHIFT);
					roll_cmd <= sat_rate(roll_diff >>> KP_RATE_SHIFT);
					pitch_cmd <= sat_rate(pitch_diff >>> KP_RATE_SHIFT);
				end
				default: state <= flight_pkg::IDLE;  // DONE, back for next sample
			endcase
		end
	end

	// Sample and target registers
	always_ff @(posedge sys_clk) begin
		if (state == flight_pkg::IDLE && imu_valid) begin
			thr_s <= throttle_val;
			yaw_s <= yaw_val;
			roll_s <= roll_val;
			pitch_s <= pitch_val;
			ex_s <= euler_x;
			ey_s <= euler_y;
			gx_s <= gyro_x;
			gy_s <= gyro_y;
			gz_s <= gyro_z;
		end
		if (state == flight_pkg::ANGLE) begin
			pitch_tgt <= pitch_err >>> KP_ANGLE_SHIFT;
			roll_tgt <= roll_err >>> KP_ANGLE_SHIFT;
			yaw_tgt <= stick_offset(yaw_s);  // Yaw is rate-only
		end
	end

	assign cmd.throttle = thr_cmd;
	assign cmd.yaw = yaw_cmd;
	assign cmd.roll = roll_cmd;
	assign cmd.pitch = pitch_cmd;
	assign cmd.cmd_valid = (state == flight_pkg::DONE);  // Third cycle after imu_valid

	assert property (@(posedge sys_clk) disable iff (!resetn)
		cmd.cmd_valid |=> !cmd.cmd_valid)
		else $error("cmd_valid held for more than one cycle");

endmodule

//--- esc_pwm.sv
module esc_pwm #(
	parameter int PWM_PERIOD_US = 2500,
	parameter int MIN_PULSE_US = 1000
) (
	input logic sys_clk,
	input logic resetn,
	input logic tick,
	motor_cmd_if.esc motors,
	output logic motor_1_pwm,
	output logic motor_2_pwm,
	output logic motor_3_pwm,
	output logic motor_4_pwm
);

	localparam int FRAME_W = $clog2(PWM_PERIOD_US);

	logic [FRAME_W-1:0] frame_cnt;  // Microseconds into the frame
	logic frame_start;
	flight_pkg::motor_rate_t upd_val [4];
	flight_pkg::motor_rate_t shadow [4];  // Latest update
	flight_pkg::motor_rate_t active [4];  // Rates for this frame
	logic [FRAME_W-1:0] high_len [4];
	logic [3:0] pwm;

	assign upd_val[0] = motors.motor_1;
	assign upd_val[1] = motors.motor_2;
	assign upd_val[2] = motors.motor_3;
	assign upd_val[3] = motors.motor_4;

	assign frame_start = tick && (frame_cnt == FRAME_W'(PWM_PERIOD_US - 1));

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			frame_cnt <= FRAME_W'(PWM_PERIOD_US - 1);  // First tick opens frame
			for (int k = 0; k < 4; k++) begin
				shadow[k] <= '0;
				active[k] <= '0;
			end
		end else begin
			if (tick)
				frame_cnt <= frame_start ? '0 : frame_cnt + 1'b1;
			for (int k = 0; k < 4; k++) begin
				if (motors.update)
					shadow[k] <= upd_val[k];
				if (frame_start)
					active[k] <= shadow[k];  // Mid-frame updates wait here
			end
		end
	end

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			high_len[k] = FRAME_W'(MIN_PULSE_US) + FRAME_W'(active[k]);
			pwm[k] = frame_cnt < high_len[k];
		end
	end

	assign motor_1_pwm = pwm[0];
	assign motor_2_pwm = pwm[1];
	assign motor_3_pwm = pwm[2];
	assign motor_4_pwm = pwm[3];

	// Longest pulse must still leave a low gap
	assert property (@(posedge sys_clk)
		PWM_PERIOD_US > MIN_PULSE_US + flight_pkg::MOTOR_MAX)
		else $error("ESC frame shorter than the longest pulse");

endmodule

//--- flight_pkg.sv
package flight_pkg;

	// Value widths carried between blocks
	typedef logic [7:0] stick_t;            // Receiver stick, 0..255
	typedef logic signed [15:0] imu_val_t;  // IMU angle or rate, 16 LSB per unit
	typedef logic signed [15:0] rate_t;     // Axis command from the controller
	typedef logic [9:0] motor_rate_t;       // Mixer output, 0..MOTOR_MAX

	// Controller sequence
	typedef enum logic [1:0] {
		IDLE,   // Waiting for an IMU sample
		ANGLE,  // Angle errors and rate targets
		RATE,   // Rate errors and saturation
		DONE    // Commands published
	} ctrl_state_t;

	localparam int STICK_CENTER = 128;  // Stick at mid position
	localparam int MOTOR_MAX = 1023;    // Motor rate ceiling
	localparam int ARM_THRESHOLD = 16;  // Throttle stick arm point

endpackage

//--- flight_top.sv
module flight_top #(
	parameter int CLKS_PER_US = 38,
	parameter int PWM_PERIOD_US = 2500,
	parameter int MIN_PULSE_US = 1000,
	parameter int KP_ANGLE_SHIFT = 2,
	parameter int KP_RATE_SHIFT = 1
) (
	input logic sys_clk,
	input logic resetn,
	input logic throttle_pwm,
	input logic yaw_pwm,
	input logic roll_pwm,
	input logic pitch_pwm,
	input logic imu_valid,                 // One cycle per IMU sample
	input flight_pkg::imu_val_t euler_x,   // Pitch angle
	input flight_pkg::imu_val_t euler_y,   // Roll angle
	input flight_pkg::imu_val_t euler_z,   // Heading, not in the P loop
	input flight_pkg::imu_val_t gyro_x,    // Pitch rate
	input flight_pkg::imu_val_t gyro_y,    // Roll rate
	input flight_pkg::imu_val_t gyro_z,    // Yaw rate
	input logic debug_led_switch_n,
	output logic motor_1_pwm,
	output logic motor_2_pwm,
	output logic motor_3_pwm,
	output logic motor_4_pwm,
	output logic [7:0] led_data_out,
	output logic [15:0] debug_leds
);

	logic tick;
	flight_pkg::stick_t throttle_val, yaw_val, roll_val, pitch_val;

	rate_cmd_if rate_cmd ();
	motor_cmd_if motor_cmd ();

	us_tick #(.CLKS_PER_US(CLKS_PER_US)) u_tick (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.tick(tick)
	);

	rc_receiver #(.MIN_PULSE_US(MIN_PULSE_US)) u_receiver (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.tick(tick),
		.throttle_pwm(throttle_pwm),
		.yaw_pwm(yaw_pwm),
		.roll_pwm(roll_pwm),
		.pitch_pwm(pitch_pwm),
		.throttle_val(throttle_val),
		.yaw_val(yaw_val),
		.roll_val(roll_val),
		.pitch_val(pitch_val)
	);

	attitude_controller #(
		.KP_ANGLE_SHIFT(KP_ANGLE_SHIFT),
		.KP_RATE_SHIFT(KP_RATE_SHIFT)
	) u_controller (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.imu_valid(imu_valid),
		.throttle_val(throttle_val),
		.yaw_val(yaw_val),
		.roll_val(roll_val),
		.pitch_val(pitch_val),
		.euler_x(euler_x),
		.euler_y(euler_y),
		.gyro_x(gyro_x),
		.gyro_y(gyro_y),
		.gyro_z(gyro_z),
		.cmd(rate_cmd.controller)
	);

	motor_mixer u_mixer (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.cmd(rate_cmd.mixer),
		.motors(motor_cmd.mixer)
	);

	esc_pwm #(
		.PWM_PERIOD_US(PWM_PERIOD_US),
		.MIN_PULSE_US(MIN_PULSE_US)
	) u_esc (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.tick(tick),
		.motors(motor_cmd.esc),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm)
	);

	// Board LEDs are active low
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			led_data_out <= 8'hAA;
			debug_leds <= 16'hAAAA;
		end else if (!debug_led_switch_n) begin
			led_data_out <= ~throttle_val;   // Throttle path
			debug_leds <= rate_cmd.throttle;
		end else begin
			led_data_out <= ~euler_x[11:4];  // Pitch path, whole degrees
			debug_leds <= gyro_x;
		end
	end

endmodule

//--- motor_cmd_if.sv
interface motor_cmd_if;

	// Saturated motor rates, held between updates
	flight_pkg::motor_rate_t motor_1;
	flight_pkg::motor_rate_t motor_2;
	flight_pkg::motor_rate_t motor_3;
	flight_pkg::motor_rate_t motor_4;
	logic update;

	modport mixer (
		output motor_1, motor_2, motor_3, motor_4, update
	);

	modport esc (
		input motor_1, motor_2, motor_3, motor_4, update
	);

endinterface

//--- motor_mixer.sv
module motor_mixer (
	input logic sys_clk,
	input logic resetn,
	rate_cmd_if.mixer cmd,
	motor_cmd_if.mixer motors
);

	logic signed [17:0] t, p, r, y;  // Widened commands
	logic signed [17:0] mix [4];
	logic armed;
	flight_pkg::motor_rate_t motor_q [4];
	logic update_q;

	function automatic flight_pkg::motor_rate_t sat_motor(input logic signed [17:0] v);
		if (v < 0)
			return '0;
		else if (v > flight_pkg::MOTOR_MAX)
			return flight_pkg::motor_rate_t'(flight_pkg::MOTOR_MAX);
		else
			return v[9:0];
	endfunction

	// Quad-X mixing
	always_comb begin
		t = cmd.throttle;
		p = cmd.pitch;
		r = cmd.roll;
		y = cmd.yaw;
		mix[0] = t + p - r + y;  // Front left
		mix[1] = t + p + r - y;  // Front right
		mix[2] = t - p + r + y;  // Rear right
		mix[3] = t - p - r - y;  // Rear left
	end

	assign armed = cmd.throttle >= flight_pkg::ARM_THRESHOLD * 4;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			update_q <= 1'b0;
			for (int k = 0; k < 4; k++)
				motor_q[k] <= '0;
		end else begin
			update_q <= cmd.cmd_valid;  // One cycle behind cmd_valid
			if (cmd.cmd_valid)
				for (int k = 0; k < 4; k++)
					motor_q[k] <= armed ? sat_motor(mix[k]) : '0;
		end
	end

	assign motors.motor_1 = motor_q[0];
	assign motors.motor_2 = motor_q[1];
	assign motors.motor_3 = motor_q[2];
	assign motors.motor_4 = motor_q[3];
	assign motors.update = update_q;

	// Commands still hold the pass that produced this update
	assert property (@(posedge sys_clk) disable iff (!resetn)
		(motors.update && !armed) |->
		(motors.motor_1 == 0 && motors.motor_2 == 0 &&
		 motors.motor_3 == 0 && motors.motor_4 == 0))
		else $error("motor driven while disarmed");

endmodule

//--- rate_cmd_if.sv
interface rate_cmd_if;

	// Per-axis commands, stable between strobes
	flight_pkg::rate_t throttle;
	flight_pkg::rate_t yaw;
	flight_pkg::rate_t roll;
	flight_pkg::rate_t pitch;
	logic cmd_valid;  // One cycle per control pass

	modport controller (
		output throttle, yaw, roll, pitch, cmd_valid
	);

	modport mixer (
		input throttle, yaw, roll, pitch, cmd_valid
	);

endinterface

//--- rc_receiver.sv
module rc_receiver #(
	parameter int MIN_PULSE_US = 1000
) (
	input logic sys_clk,
	input logic resetn,
	input logic tick,
	input logic throttle_pwm,
	input logic yaw_pwm,
	input logic roll_pwm,
	input logic pitch_pwm,
	output flight_pkg::stick_t throttle_val,
	output flight_pkg::stick_t yaw_val,
	output flight_pkg::stick_t roll_val,
	output flight_pkg::stick_t pitch_val
);

	localparam int WIDTH_W = 12;  // Up to 4095 us per pulse

	logic [3:0] pwm_in;
	flight_pkg::stick_t stick [4];

	// Lane order: throttle, yaw, roll, pitch
	assign pwm_in = {pitch_pwm, roll_pwm, yaw_pwm, throttle_pwm};

	genvar i;
	generate
		for (i = 0; i < 4; i++) begin : g_lane
			logic [1:0] sync_q;           // Two-flop synchronizer
			logic level_d;                // Previous synced level
			logic [WIDTH_W-1:0] width_cnt;
			logic [WIDTH_W-1:0] excess;   // Width above the zero point
			logic [9:0] clamped;
			flight_pkg::stick_t stick_q;

			always_ff @(posedge sys_clk) begin
				if (!resetn) begin
					sync_q <= '0;
					level_d <= 1'b0;
					width_cnt <= '0;
					stick_q <= '0;
				end else begin
					sync_q <= {sync_q[0], pwm_in[i]};
					level_d <= sync_q[1];
					if (sync_q[1] && !level_d)
						width_cnt <= '0;                 // Rising edge, restart
					else if (sync_q[1] && tick)
						width_cnt <= width_cnt + 1'b1;   // Count us while high
					if (!sync_q[1] && level_d)
						stick_q <= clamped[9:2];         // Falling edge, take width
				end
			end

			// Clamp to 0..1023 above the zero point, then scale by 1/4
			always_comb begin
				excess = width_cnt - WIDTH_W'(MIN_PULSE_US);
				if (width_cnt <= WIDTH_W'(MIN_PULSE_US))
					clamped = '0;
				else if (excess > WIDTH_W'(1023))
					clamped = 10'd1023;
				else
					clamped = excess[9:0];
			end

			assign stick[i] = stick_q;

			// Pulse never long enough to roll the counter over
			assert property (@(posedge sys_clk) disable iff (!resetn)
				(sync_q[1] && tick) |-> (width_cnt != '1))
				else $error("rc_receiver lane %0d width counter wrapped", i);
		end
	endgenerate

	assign throttle_val = stick[0];
	assign yaw_val = stick[1];
	assign roll_val = stick[2];
	assign pitch_val = stick[3];

endmodule

//--- sim.f
flight_pkg.sv
rate_cmd_if.sv
motor_cmd_if.sv
us_tick.sv
rc_receiver.sv
attitude_controller.sv
motor_mixer.sv
esc_pwm.sv
flight_top.sv
tb_flight_top.sv

//--- tb_flight_top.sv
module tb_flight_top;

	localparam int CLKS_PER_US = 2;
	localparam int MIN_PULSE_US = 1000;
	localparam int KP_ANGLE_SHIFT = 2;
	localparam int KP_RATE_SHIFT = 1;
	localparam int DRIVE_DELAY = 2;                        // After the rising edge
	localparam int FRAME_CYCLES = 2500 * CLKS_PER_US;      // One ESC frame
	localparam int RC_CYCLES = (2100 + 10) * CLKS_PER_US;  // Longest RC pulse plus settle
	localparam int PASS_WAITS = 6;                         // Control passes checked on the motors
	localparam int RC_SENDS = 7;
	// Each checked pass may span up to three frames
	localparam int MAX_CYCLES = 3 * PASS_WAITS * FRAME_CYCLES + RC_SENDS * RC_CYCLES + 2000;

	logic sys_clk;
	logic resetn;
	logic throttle_pwm, yaw_pwm, roll_pwm, pitch_pwm;
	logic imu_valid;
	flight_pkg::imu_val_t euler_x, euler_y, euler_z;
	flight_pkg::imu_val_t gyro_x, gyro_y, gyro_z;
	logic debug_led_switch_n;
	logic motor_1_pwm, motor_2_pwm, motor_3_pwm, motor_4_pwm;
	logic [7:0] led_data_out;
	logic [15:0] debug_leds;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int stk [4];        // Model sticks: throttle, yaw, roll, pitch
	int hi_cnt [4];     // Cycles high in the running pulse
	int width_us [4];   // Last finished pulse
	int pulses [4];     // Finished pulses per motor
	logic tick_seen;
	logic [3:0] pwm_vec;

	flight_top #(.CLKS_PER_US(CLKS_PER_US)) dut (
		.sys_clk(sys_clk),
		.resetn(resetn),
		.throttle_pwm(throttle_pwm),
		.yaw_pwm(yaw_pwm),
		.roll_pwm(roll_pwm),
		.pitch_pwm(pitch_pwm),
		.imu_valid(imu_valid),
		.euler_x(euler_x),
		.euler_y(euler_y),
		.euler_z(euler_z),
		.gyro_x(gyro_x),
		.gyro_y(gyro_y),
		.gyro_z(gyro_z),
		.debug_led_switch_n(debug_led_switch_n),
		.motor_1_pwm(motor_1_pwm),
		.motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm),
		.motor_4_pwm(motor_4_pwm),
		.led_data_out(led_data_out),
		.debug_leds(debug_leds)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	assign pwm_vec = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};

	// Run limit
	always @(posedge sys_clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("tests failed");
			$finish;
		end
	end

	always @(posedge sys_clk) begin
		if (!resetn)
			tick_seen <= 1'b0;
		else if (dut.tick)
			tick_seen <= 1'b1;
	end

	// Pulse widths, sampled away from the active edge
	always @(negedge sys_clk) begin
		for (int k = 0; k < 4; k++) begin
			if (!resetn)
				hi_cnt[k] = 0;
			else if (pwm_vec[k])
				hi_cnt[k]++;
			else if (hi_cnt[k] != 0) begin
				width_us[k] = hi_cnt[k] / CLKS_PER_US;
				pulses[k]++;
				hi_cnt[k] = 0;
			end
		end
	end

	// LEDs take their reset pattern
	assert property (@(posedge sys_clk) !resetn |=>
		(led_data_out == 8'hAA && debug_leds == 16'hAAAA))
	else begin
		errors++;
		$display("[FAIL] reset_leds: expected aa/aaaa, actual %h/%h",
			$sampled(led_data_out), $sampled(debug_leds));
	end

	// ESC quiet until its first frame opens
	assert property (@(posedge sys_clk) disable iff (!resetn)
		!tick_seen |-> (pwm_vec == 4'b0000))
	else begin
		errors++;
		$display("Motor output went high before the first microsecond tick");
	end

	task automatic check_val(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual)
		else begin
			errors++;
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	function automatic int stick_of(input int w);
		int e;
		e = w - MIN_PULSE_US;
		if (e < 0)
			e = 0;
		if (e > 1023)
			e = 1023;
		return e / 4;
	endfunction

	function automatic int sat16(input int v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return v;
	endfunction

	// One axis of the cascade, angle stage optional
	function automatic int axis_cmd(input int s, input int angle, input int gyro,
		input bit with_angle);
		int target;
		target = (s - flight_pkg::STICK_CENTER) * 4;
		if (with_angle)
			target = (target - angle) >>> KP_ANGLE_SHIFT;
		return sat16((target - gyro) >>> KP_RATE_SHIFT);
	endfunction

	function automatic int motor_rate(input int t, input int v);
		if (t < flight_pkg::ARM_THRESHOLD * 4)
			return 0;  // Disarmed
		if (v < 0)
			return 0;
		if (v > flight_pkg::MOTOR_MAX)
			return flight_pkg::MOTOR_MAX;
		return v;
	endfunction

	function automatic int rand_range(input int lim);
		return int'($urandom_range(2 * lim)) - lim;
	endfunction

	// One pulse on each RC line, all rising together
	task automatic send_rc(input int thr_us, input int yaw_us, input int roll_us,
		input int pitch_us);
		int hi [4];
		int longest;
		int c;
		// One extra clock keeps the tick count whole
		hi[0] = CLKS_PER_US * thr_us + 1;
		hi[1] = CLKS_PER_US * yaw_us + 1;
		hi[2] = CLKS_PER_US * roll_us + 1;
		hi[3] = CLKS_PER_US * pitch_us + 1;
		longest = 0;
		for (c = 0; c < 4; c++)
			if (hi[c] > longest)
				longest = hi[c];
		for (c = 0; c <= longest; c++) begin
			@(posedge sys_clk);
			#DRIVE_DELAY;
			throttle_pwm = c < hi[0];
			yaw_pwm = c < hi[1];
			roll_pwm = c < hi[2];
			pitch_pwm = c < hi[3];
		end
		stk[0] = stick_of(thr_us);
		stk[1] = stick_of(yaw_us);
		stk[2] = stick_of(roll_us);
		stk[3] = stick_of(pitch_us);
		repeat (8) @(posedge sys_clk);  // Sync, edge detect, stick and LED registers
	endtask

	task automatic send_imu(input int ex, input int ey, input int ez, input int gx,
		input int gy, input int gz);
		@(posedge sys_clk);
		#DRIVE_DELAY;
		euler_x = 16'(ex);
		euler_y = 16'(ey);
		euler_z = 16'(ez);
		gyro_x = 16'(gx);
		gyro_y = 16'(gy);
		gyro_z = 16'(gz);
		imu_valid = 1'b1;
		@(posedge sys_clk);
		#DRIVE_DELAY;
		imu_valid = 1'b0;
	endtask

	// Control pass, then two finished pulses per motor so the new frame is measured
	task automatic run_pass(input string name, input int ex, input int ey, input int gx,
		input int gy, input int gz);
		int t, p, r, y;
		int exp_m [4];
		int start [4];
		bit done;
		t = stk[0] * 4;
		p = axis_cmd(stk[3], ex, gx, 1'b1);  // Pitch about x
		r = axis_cmd(stk[2], ey, gy, 1'b1);  // Roll about y
		y = axis_cmd(stk[1], 0, gz, 1'b0);   // Yaw is rate only
		exp_m[0] = motor_rate(t, t + p - r + y);
		exp_m[1] = motor_rate(t, t + p + r - y);
		exp_m[2] = motor_rate(t, t - p + r + y);
		exp_m[3] = motor_rate(t, t - p - r - y);
		send_imu(ex, ey, rand_range(256), gx, gy, gz);
		for (int k = 0; k < 4; k++)
			start[k] = pulses[k];
		done = 1'b0;
		while (!done) begin
			@(posedge sys_clk);
			done = 1'b1;
			for (int k = 0; k < 4; k++)
				if (pulses[k] < start[k] + 2)
					done = 1'b0;
		end
		for (int k = 0; k < 4; k++)
			check_val($sformatf("%s motor_%0d", name, k + 1),
				MIN_PULSE_US + exp_m[k], width_us[k]);
	endtask

	initial begin
		int rc_us [4];
		int ex, gx;
		void'($urandom(25442));
		resetn = 1'b0;
		throttle_pwm = 1'b0;
		yaw_pwm = 1'b0;
		roll_pwm = 1'b0;
		pitch_pwm = 1'b0;
		imu_valid = 1'b0;
		euler_x = '0;
		euler_y = '0;
		euler_z = '0;
		gyro_x = '0;
		gyro_y = '0;
		gyro_z = '0;
		debug_led_switch_n = 1'b0;  // Throttle path on the LEDs
		for (int k = 0; k < 4; k++) begin
			stk[k] = 0;
			hi_cnt[k] = 0;
			width_us[k] = 0;
			pulses[k] = 0;
		end
		repeat (4) @(posedge sys_clk);
		#DRIVE_DELAY;
		resetn = 1'b1;

		// Receiver conversion, both clamps
		rc_us = '{900, 1000, 1500, 2100};
		for (int i = 0; i < 4; i++) begin
			send_rc(rc_us[i], 1512, 1512, 1512);
			check_val($sformatf("rc_convert %0d us", rc_us[i]),
				(~stk[0]) & 8'hFF, led_data_out);
		end

		// Throttle below arm point
		send_rc(1040, 1512, 1512, 1512);
		run_pass("disarmed", 0, 0, 0, 0, 0);

		// Level hover
		send_rc(1800, 1512, 1512, 1512);
		run_pass("hover", 0, 0, 0, 0, 0);
		check_val("hover debug_leds", stk[0] * 4, debug_leds);

		// Off-center sticks, random attitude
		send_rc(1600, 1300, 1700, 1400);
		for (int i = 0; i < 3; i++)
			run_pass($sformatf("mix %0d", i), rand_range(200), rand_range(200),
				rand_range(300), rand_range(300), rand_range(300));
		run_pass("mix saturate", 0, 0, -3000, 0, 0);  // Front pair at max, rear at 0

		// Pitch path on the LEDs
		@(posedge sys_clk);
		#DRIVE_DELAY;
		debug_led_switch_n = 1'b1;
		for (int i = 0; i < 3; i++) begin
			ex = rand_range(32767);
			gx = rand_range(32767);
			euler_x = 16'(ex);
			gyro_x = 16'(gx);
			repeat (2) @(posedge sys_clk);
			#DRIVE_DELAY;
			check_val("led_pitch led_data_out", ((ex >> 4) & 8'hFF) ^ 8'hFF, led_data_out);
			check_val("led_pitch debug_leds", gx & 16'hFFFF, debug_leds);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- us_tick.sv
module us_tick #(
	parameter int CLKS_PER_US = 38
) (
	input logic sys_clk,
	input logic resetn,
	output logic tick
);

	localparam int CNT_W = (CLKS_PER_US > 1) ? $clog2(CLKS_PER_US) : 1;

	logic [CNT_W-1:0] div_cnt;  // Clocks within the current microsecond

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			div_cnt <= '0;
			tick <= 1'b0;
		end else if (div_cnt == CNT_W'(CLKS_PER_US - 1)) begin
			div_cnt <= '0;  // Wrap
			tick <= 1'b1;   // Single-cycle pulse
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule
